/* hw/aes_pkg.sv */
//////////////////////////////
// aes package
// types, sizes and constants of the AES-128 decipher core,
// GF(2^8) arithmetic, S-box generators and the inverse
// state transforms of FIPS 197
//////////////////////////////
package aes_pkg;

    typedef logic [7:0]  byte_t;     // one GF(2^8) element
    typedef logic [31:0] word_t;     // column or key word, row 0 in top byte
    typedef word_t [3:0] block_t;    // index 3 holds column 0
    typedef logic [3:0]  round_t;
    typedef logic [1:0]  col_sel_t;

    localparam int    NUM_ROUNDS     = 10;
    localparam int    COLS_PER_BLOCK = 4;
    localparam int    SBOX_SIZE      = 256;
    localparam int    DEC_LATENCY    = NUM_ROUNDS * (COLS_PER_BLOCK + 1);  // 50 cycles
    localparam byte_t RCON_LAST      = 8'h36;  // rcon of encipher round 10

    // xtime, multiply by x modulo x^8+x^4+x^3+x+1
    function automatic byte_t gf_mul2(byte_t x);
        return {x[6:0], 1'b0} ^ (8'h1b & {8{x[7]}});
    endfunction

    // divide by x, inverse of xtime
    function automatic byte_t gf_div2(byte_t x);
        return {1'b0, x[7:1]} ^ (8'h8d & {8{x[0]}});
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ sh;   // shift and add
            sh = gf_mul2(sh);
        end
        return acc;
    endfunction

    function automatic byte_t gf_mul9(byte_t x);
        return gf_mul(x, 8'h09);
    endfunction

    function automatic byte_t gf_mul11(byte_t x);
        return gf_mul(x, 8'h0b);
    endfunction

    function automatic byte_t gf_mul13(byte_t x);
        return gf_mul(x, 8'h0d);
    endfunction

    function automatic byte_t gf_mul14(byte_t x);
        return gf_mul(x, 8'h0e);
    endfunction

    // multiplicative inverse as x^254, zero maps to zero
    function automatic byte_t gf_inv(byte_t x);
        byte_t p;
        p = 8'h01;
        for (int i = 7; i >= 0; i--) begin
            p = gf_mul(p, p);
            if (i != 0) p = gf_mul(p, x);  // exponent 8'hfe
        end
        return p;
    endfunction

    function automatic byte_t sbox_calc(byte_t x);
        byte_t i;
        i = gf_inv(x);
        // affine map over the inverse
        return i ^ {i[6:0], i[7]} ^ {i[5:0], i[7:6]} ^ {i[4:0], i[7:5]}
                 ^ {i[3:0], i[7:4]} ^ 8'h63;
    endfunction

    function automatic byte_t sbox_inv_calc(byte_t y);
        byte_t a;
        a = {y[6:0], y[7]} ^ {y[4:0], y[7:5]} ^ {y[1:0], y[7:2]} ^ 8'h05;  // undo affine
        return gf_inv(a);
    endfunction

    function automatic word_t inv_mix_column(word_t w);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        a0 = w[31:24];   // row 0
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {gf_mul14(a0) ^ gf_mul11(a1) ^ gf_mul13(a2) ^ gf_mul9(a3),
                gf_mul9(a0) ^ gf_mul14(a1) ^ gf_mul11(a2) ^ gf_mul13(a3),
                gf_mul13(a0) ^ gf_mul9(a1) ^ gf_mul14(a2) ^ gf_mul11(a3),
                gf_mul11(a0) ^ gf_mul13(a1) ^ gf_mul9(a2) ^ gf_mul14(a3)};
    endfunction

    function automatic block_t inv_mix_columns(block_t s);
        block_t res;
        for (int c = 0; c < 4; c++) begin
            res[c] = inv_mix_column(s[c]);
        end
        return res;
    endfunction

    // row r moves r columns to the right
    function automatic block_t inv_shift_rows(block_t s);
        block_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[3 - c][8*(3-r) +: 8] = s[3 - ((c - r + 4) % 4)][8*(3-r) +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* hw/aes_sbox_word.sv */
//////////////////////////////
// aes sbox word
// four parallel byte substitutions through a
// forward or inverse S-box table
//////////////////////////////
`timescale 1ns/1ps

module aes_sbox_word #(
    parameter bit inverse = 1'b0           // 1 selects the inverse table
) (
    input  aes_pkg::word_t x,
    output aes_pkg::word_t y
);
    import aes_pkg::*;

    byte_t lut [SBOX_SIZE];                 // 256 entry table

    // table built once from the GF(2^8) generators
    initial begin
        for (int m = 0; m < SBOX_SIZE; m++) begin
            if (inverse) begin
                lut[m] = sbox_inv_calc(byte_t'(m));
            end else begin
                lut[m] = sbox_calc(byte_t'(m));
            end
        end
    end

    for (genvar b = 0; b < 4; b++) begin : g_byte
        assign y[8*b +: 8] = lut[x[8*b +: 8]];  // one lookup per byte
    end

endmodule

/* hw/aes_key_unexpand.sv */
//////////////////////////////
// aes key unexpand
// holds the current round key and rcon and runs the
// AES-128 key schedule one step backwards per pulse
//////////////////////////////
`timescale 1ns/1ps

module aes_key_unexpand (
    input  logic            clk,
    input  logic            reset,
    input  logic            load,          // take the supplied key
    input  aes_pkg::block_t cipher_key,
    input  logic            step_key,      // one schedule step back
    output aes_pkg::word_t  sub_word,      // to the forward S-box
    input  aes_pkg::word_t  sub_word_s,    // substituted word, same cycle
    output aes_pkg::block_t round_key
);
    import aes_pkg::*;

    block_t key_q;
    byte_t  rcon_q;
    word_t  w0;
    word_t  w1;
    word_t  w2;
    word_t  w3;
    word_t  n0;
    word_t  n1;
    word_t  n2;
    word_t  n3;

    // old key words, column 0 first
    assign w0 = key_q[3];
    assign w1 = key_q[2];
    assign w2 = key_q[1];
    assign w3 = key_q[0];

    // previous key words 1 to 3 fall out of adjacent xors
    assign n3 = w3 ^ w2;
    assign n2 = w2 ^ w1;
    assign n1 = w1 ^ w0;

    assign sub_word = {n3[23:0], n3[31:24]};            // RotWord before SubWord
    assign n0       = w0 ^ sub_word_s ^ {rcon_q, 24'h0};

    always_ff @(posedge clk) begin
        if (reset) begin
            rcon_q <= RCON_LAST;
        end else if (load) begin
            rcon_q <= RCON_LAST;
        end else if (step_key) begin
            rcon_q <= gf_div2(rcon_q);                  // 36, 1b, 80, 40 ...
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= cipher_key;
        end else if (step_key) begin
            key_q <= {n0, n1, n2, n3};
        end
    end

    assign round_key = key_q;

endmodule

/* hw/aes_state_path.sv */
//////////////////////////////
// aes state path
// 128-bit decipher state, column-wise inverse
// substitution and the combined AddRoundKey,
// InvMixColumns and InvShiftRows step
//////////////////////////////
`timescale 1ns/1ps

module aes_state_path (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,         // acceptance cycle
    input  aes_pkg::block_t      ciphertext,
    input  aes_pkg::block_t      cipher_key,
    input  logic                 sub_col,      // substitute one column
    input  aes_pkg::col_sel_t    col_sel,
    input  logic                 add_key,      // round closing step
    input  logic                 last_round,
    input  aes_pkg::block_t      round_key,
    output aes_pkg::word_t       sbox_in,
    input  aes_pkg::word_t       sbox_out,
    output aes_pkg::block_t      state
);
    import aes_pkg::*;

    block_t   state_q;
    block_t   keyed;        // state with round key added
    block_t   mixed;        // full inner round result
    block_t   first;        // initial round from the inputs
    col_sel_t col_idx;      // array index of the selected column

    // column 0 sits at index 3
    assign col_idx = col_sel_t'(COLS_PER_BLOCK - 1) - col_sel;
    assign sbox_in = state_q[col_idx];

    assign keyed = state_q ^ round_key;
    assign mixed = inv_shift_rows(inv_mix_columns(keyed));
    assign first = inv_shift_rows(ciphertext ^ cipher_key);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= '0;
        end else if (load) begin
            state_q <= first;
        end else if (sub_col) begin
            state_q[col_idx] <= sbox_out;       // inverse S-box writeback
        end else if (add_key) begin
            if (last_round) begin
                state_q <= keyed;               // round 0, no mix or shift
            end else begin
                state_q <= mixed;
            end
        end
    end

    // holds the plaintext once busy drops
    assign state = state_q;

endmodule

/* hw/aes_dec_ctrl.sv */
//////////////////////////////
// aes decipher control
// busy flag, round and column counters and the
// per-round step pulses, five cycles per round
//////////////////////////////
`timescale 1ns/1ps

module aes_dec_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s_aes_valid,
    output logic                 busy,
    output logic                 load,         // accept this cycle
    output logic                 sub_col,      // column substitution phase
    output aes_pkg::col_sel_t    col_sel,
    output logic                 add_key,      // round closing pulse
    output logic                 last_round,   // round counter at zero
    output logic                 step_key      // key schedule step back
);
    import aes_pkg::*;

    round_t   round_cnt;    // 9 down to 0
    col_sel_t col_cnt;
    logic     col_done;     // fourth column this cycle

    assign load       = s_aes_valid && !busy;   // valid is a level, sampled when idle
    assign last_round = (round_cnt == '0);
    assign col_done   = sub_col && (col_cnt == col_sel_t'(COLS_PER_BLOCK - 1));
    assign col_sel    = col_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            sub_col   <= 1'b0;
            add_key   <= 1'b0;
            step_key  <= 1'b0;
            col_cnt   <= '0;
            round_cnt <= '0;
        end else begin
            add_key  <= 1'b0;                   // pulses
            step_key <= 1'b0;
            if (load) begin
                busy      <= 1'b1;
                sub_col   <= 1'b1;
                col_cnt   <= '0;
                round_cnt <= round_t'(NUM_ROUNDS - 1);
                step_key  <= 1'b1;              // supplied key to round key 9
            end
            if (sub_col) begin
                col_cnt <= col_cnt + 2'd1;      // wraps to 0 after column 3
            end
            if (col_done) begin
                sub_col  <= 1'b0;
                add_key  <= 1'b1;
                step_key <= !last_round;        // no step after round key 0
            end
            if (add_key) begin
                if (last_round) begin
                    busy <= 1'b0;               // plaintext final
                end else begin
                    round_cnt <= round_cnt - 4'd1;
                    sub_col   <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/aes_dec_top.sv */
//////////////////////////////
// aes-128 decipher top
// word-serial FIPS 197 inverse cipher, one block in
// flight, plaintext 50 cycles after acceptance
//////////////////////////////
`timescale 1ns/1ps

module aes_dec_top (
    input  logic            clk,
    input  logic            reset,
    input  aes_pkg::block_t s_aes_key,      // final round key of the schedule
    input  aes_pkg::block_t s_aes_block,    // ciphertext
    input  logic            s_aes_valid,
    output logic            s_aes_ready,
    output aes_pkg::block_t m_aes_block     // plaintext
);
    import aes_pkg::*;

    logic     busy;
    logic     load;
    logic     sub_col;
    col_sel_t col_sel;
    logic     add_key;
    logic     last_round;
    logic     step_key;
    word_t    sbox_in;
    word_t    sbox_out;
    word_t    sub_word;
    word_t    sub_word_s;
    block_t   round_key;

    assign s_aes_ready = !(s_aes_valid || busy);  // low while valid or busy

    aes_dec_ctrl i_aes_dec_ctrl (
        .clk, .reset, .s_aes_valid, .busy, .load, .sub_col,
        .col_sel, .add_key, .last_round, .step_key
    );

    aes_state_path i_aes_state_path (
        .clk, .reset, .load,
        .ciphertext (s_aes_block),
        .cipher_key (s_aes_key),
        .sub_col, .col_sel, .add_key, .last_round, .round_key,
        .sbox_in, .sbox_out,
        .state      (m_aes_block)
    );

    aes_key_unexpand i_aes_key_unexpand (
        .clk, .reset, .load,
        .cipher_key (s_aes_key),
        .step_key, .sub_word, .sub_word_s, .round_key
    );

    aes_sbox_word #(.inverse(1'b1)) state_sbox (.x(sbox_in), .y(sbox_out));    // InvSubBytes
    aes_sbox_word #(.inverse(1'b0)) key_sbox (.x(sub_word), .y(sub_word_s));   // key SubWord

endmodule

/* tests/tb_clock_gen.sv */
//////////////////////////////
// testbench clock and reset
// 40 ns clock, reset high for
// the first three rising edges
//////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // half of the 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);                 // released on a falling edge
        reset = 1'b0;
    end

endmodule

/* tests/aes_dec_ctrl_assert.sv */
//////////////////////////////
// aes decipher control checks
// acceptance from idle, five-cycle round
// shape and the end of busy
//////////////////////////////
`timescale 1ns/1ps

module aes_dec_ctrl_assert (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic load,
    input logic sub_col,
    input logic add_key,
    input logic last_round
);

    // a block is only taken with no round in flight, and it starts at once
    load_idle: assert property (@(posedge clk) disable iff (reset)
        load |-> !sub_col && !add_key ##1 busy && sub_col)
        else $error("load seen while a block is in flight, or block not started");

    // four column cycles, then the round closing pulse
    round_shape: assert property (@(posedge clk) disable iff (reset)
        add_key |-> $past(sub_col, 1) && $past(sub_col, 2) && $past(sub_col, 3)
                    && $past(sub_col, 4) && !$past(sub_col, 5))
        else $error("add_key not preceded by exactly four sub_col cycles");

    // done only after round 0, or cleared by reset
    busy_end: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(reset) || $past(add_key && last_round))
        else $error("busy fell outside the last add_key cycle");

endmodule

/* tests/aes_dec_tb.sv */
//////////////////////////////
// aes-128 decipher testbench
// FIPS 197 vector table, exact latency on ready,
// inputs scrambled while busy, idle stability
// and a reset in the middle of a block
//////////////////////////////
`timescale 1ns/1ps

module aes_dec_tb;
    import aes_pkg::*;

    typedef struct packed {
        block_t key;        // round 10 key, the core runs the schedule backwards from it
        block_t cipher;
        block_t plain;
    } vector_t;

    localparam int NUM_ROWS       = 4;
    localparam int NUM_BLOCKS     = NUM_ROWS + 2;   // rows, interrupted block, retry
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * (DEC_LATENCY + 10) + 20;

    logic        clk;
    logic        por_reset;
    logic        mid_reset;
    logic        reset;
    block_t      s_aes_key;
    block_t      s_aes_block;
    logic        s_aes_valid;
    logic        s_aes_ready;
    block_t      m_aes_block;
    vector_t     vectors [NUM_ROWS];
    int          cycle_cnt;
    int          error_count;
    int          row;
    int unsigned gap;

    assign reset = por_reset | mid_reset;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(por_reset));

    aes_dec_top i_aes_dec_top (
        .clk         (clk),
        .reset       (reset),
        .s_aes_key   (s_aes_key),
        .s_aes_block (s_aes_block),
        .s_aes_valid (s_aes_valid),
        .s_aes_ready (s_aes_ready),
        .m_aes_block (m_aes_block)
    );

    bind aes_dec_ctrl aes_dec_ctrl_assert i_aes_dec_ctrl_assert (
        .clk(clk), .reset(reset), .busy(busy), .load(load),
        .sub_col(sub_col), .add_key(add_key), .last_round(last_round)
    );

    // C.1 cipher key 000102..0f, B cipher key 2b7e1516..4f3c
    initial begin
        vectors[0] = '{key:    128'h13111d7fe3944a17f307a78b4d2b30c5,
                       cipher: 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                       plain:  128'h00112233445566778899aabbccddeeff};
        vectors[1] = '{key:    128'hd014f9a8c9ee2589e13f0cc8b6630ca6,
                       cipher: 128'h3925841d02dc09fbdc118597196a0b32,
                       plain:  128'h3243f6a8885a308d313198a2e0370734};
        vectors[2] = vectors[0];   // both rows once more
        vectors[3] = vectors[1];
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_block(input block_t got, input block_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[FAIL] time %0t %s: got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[FAIL] time %0t %s: got %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic scramble_inputs();
        s_aes_key   = {$urandom, $urandom, $urandom, $urandom};
        s_aes_block = {$urandom, $urandom, $urandom, $urandom};
    endtask

    // valid for one cycle, then ready tracked edge by edge up to the latency
    task automatic decrypt_row(input int r);
        int edges;
        bit done;
        edges       = 0;
        done        = 1'b0;
        s_aes_key   = vectors[r].key;
        s_aes_block = vectors[r].cipher;
        s_aes_valid = 1'b1;
        @(posedge clk);                              // acceptance edge
        while (!done) begin
            @(negedge clk);
            check_bit(s_aes_ready, edges >= DEC_LATENCY,
                      $sformatf("ready, row %0d, %0d edges after accept", r, edges));
            s_aes_valid = 1'b0;
            scramble_inputs();                       // core must ignore these
            done = (edges >= DEC_LATENCY);
            if (!done) begin
                @(posedge clk);
                edges++;
            end
        end
        check_block(m_aes_block, vectors[r].plain, $sformatf("plaintext, row %0d", r));
    endtask

    task automatic hold_idle(input int unsigned cycles, input block_t plain);
        repeat (cycles) begin
            @(posedge clk);
            @(negedge clk);
            check_bit(s_aes_ready, 1'b1, "ready while idle");
            check_block(m_aes_block, plain, "plaintext held while idle");
            scramble_inputs();
        end
    endtask

    // start a block and reset it halfway through the rounds
    task automatic interrupt_row(input int r);
        s_aes_key   = vectors[r].key;
        s_aes_block = vectors[r].cipher;
        s_aes_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        s_aes_valid = 1'b0;
        repeat (DEC_LATENCY / 2) @(negedge clk);
        mid_reset = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit(s_aes_ready, 1'b1, "ready during mid-block reset");
        mid_reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit(s_aes_ready, 1'b1, "ready after mid-block reset");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout: run not finished within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    initial begin
        mid_reset   = 1'b0;
        s_aes_valid = 1'b0;
        s_aes_key   = '0;
        s_aes_block = '0;
        cycle_cnt   = 0;
        error_count = 0;
        void'($urandom(32'hb80c));
        @(negedge reset);                            // power-on reset ends on a falling edge
        check_bit(s_aes_ready, 1'b1, "ready after power-on reset");
        for (row = 0; row < NUM_ROWS; row++) begin
            decrypt_row(row);
            gap = $urandom % 8;                      // idle gap 0 to 7 cycles
            hold_idle(gap, vectors[row].plain);
        end
        interrupt_row(0);
        decrypt_row(1);
        hold_idle(2, vectors[1].plain);
        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d checks failed", error_count));
        end
    end

endmodule

/* compile.f */
hw/aes_pkg.sv
hw/aes_sbox_word.sv
hw/aes_key_unexpand.sv
hw/aes_state_path.sv
hw/aes_dec_ctrl.sv
hw/aes_dec_top.sv
tests/tb_clock_gen.sv
tests/aes_dec_ctrl_assert.sv
tests/aes_dec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the AES-128 decipher testbench with Verilator and run it
# exit status is the simulator's: nonzero on any failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module aes_dec_tb -o aes_dec_sim &&
./obj_dir/aes_dec_sim ||
exit 1
